// File: hw/dii_pkg.sv
`default_nettype none

// Debug interconnect flit format and packet header constants
package dii_pkg;

   // One flit on a debug link
   typedef struct packed {
      logic        valid;
      logic        last;   // Closes the packet
      logic [15:0] data;
   } dii_flit_t;

   // Destination, source and flags
   localparam int DII_HDR_FLITS = 3;

   // Event packet type in the two top bits with subtype and reserved bits zero
   localparam logic [15:0] DII_FLAGS_EVENT = 16'h8000;

   // Longest packet on the interconnect including its header
   localparam int MAX_PKT_LEN = 8;

endpackage

`default_nettype wire

// File: hw/mam_pkg.sv
`default_nettype none

// Memory port of the debug memory access module
package mam_pkg;

   localparam int DATA_WIDTH  = 32;
   localparam int ADDR_WIDTH  = 32;
   localparam int DATA_BYTES  = DATA_WIDTH / 8;
   localparam int WORD_FLITS  = DATA_WIDTH / 16;  // Flits per memory word
   localparam int ADDR_FLITS  = ADDR_WIDTH / 16;  // Flits per address
   localparam int BEATS_WIDTH = 13;

   typedef logic [DATA_WIDTH-1:0] mam_word_t;
   typedef logic [DATA_BYTES-1:0] mam_strb_t;

   // Memory access request
   typedef struct packed {
      logic                   we;
      logic                   burst;   // Incrementing burst
      logic [ADDR_WIDTH-1:0]  addr;
      logic [BEATS_WIDTH-1:0] beats;
   } mam_req_t;

   // How to answer a read
   typedef struct packed {
      logic [15:0]            src;     // Requester that becomes the destination
      logic [BEATS_WIDTH-1:0] beats;
   } mam_read_job_t;

   typedef enum logic [1:0] {
      ACCESS_READ,
      ACCESS_WRITE_SINGLE,
      ACCESS_WRITE_BURST
   } mam_kind_e;

   typedef enum logic [3:0] {
      IN_IDLE, IN_SRC, IN_FLAGS, IN_HDR, IN_ADDR, IN_REQUEST,
      IN_WRITE_DATA, IN_WRITE_WAIT, IN_SKIP_HDR, IN_READ_JOB
   } ingress_state_e;

   typedef enum logic [1:0] {EG_IDLE, EG_HDR, EG_DATA} egress_state_e;

endpackage

`default_nettype wire

// File: hw/mam_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module mam_ingress
   import dii_pkg::*;
   import mam_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  dii_flit_t     debug_in,
   output logic          debug_in_ready,
   output logic          req_valid,
   output mam_req_t      req,
   input  logic          req_ready,
   output logic          write_valid,
   output mam_word_t     write_data,
   output mam_strb_t     write_strb,
   input  logic          write_ready,
   output logic          job_valid,
   output mam_read_job_t read_job,
   input  logic          job_ready
);

   ingress_state_e state;

   logic [$clog2(DII_HDR_FLITS)-1:0] flit_cnt;  // Address or skipped header flits
   logic [$clog2(WORD_FLITS)-1:0]    word_cnt;  // Position inside the current word
   logic                             last_seen; // Last accepted flit closed its packet

   logic [15:0]            src_q;
   mam_kind_e              kind_q;
   logic                   burst_q;
   logic [BEATS_WIDTH-1:0] beats_q;   // Words still to come
   mam_strb_t              strb_q;
   logic [ADDR_WIDTH-1:0]  addr_q;
   mam_word_t              word_q;

   logic in_xfer;
   logic word_done;

   always_comb begin
      case (state)
         IN_IDLE, IN_SRC, IN_FLAGS, IN_HDR, IN_ADDR, IN_WRITE_DATA, IN_SKIP_HDR:
            debug_in_ready = 1'b1;
         default:
            debug_in_ready = 1'b0;
      endcase
   end

   assign in_xfer   = debug_in.valid && debug_in_ready;
   assign word_done = int'(word_cnt) == WORD_FLITS - 1;

   assign req_valid = (state == IN_REQUEST);
   assign req.we    = (kind_q != ACCESS_READ);
   assign req.burst = burst_q;
   assign req.addr  = addr_q;
   assign req.beats = beats_q;

   assign write_valid = (state == IN_WRITE_WAIT);
   assign write_data  = word_q;
   assign write_strb  = (kind_q == ACCESS_WRITE_SINGLE) ? strb_q : '1; // Bursts write full words

   assign job_valid      = (state == IN_READ_JOB);
   assign read_job.src   = src_q;
   assign read_job.beats = beats_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IN_IDLE;
         flit_cnt  <= '0;
         word_cnt  <= '0;
         last_seen <= 1'b0;
      end else begin
         case (state)
            IN_IDLE: begin
               if (in_xfer) state <= IN_SRC;   // Destination flit dropped
            end
            IN_SRC: begin
               if (in_xfer) begin
                  src_q <= debug_in.data;
                  state <= IN_FLAGS;
               end
            end
            IN_FLAGS: begin
               if (in_xfer) state <= IN_HDR;
            end
            IN_HDR: begin
               if (in_xfer) begin
                  burst_q <= debug_in.data[14];
                  strb_q  <= debug_in.data[DATA_BYTES-1:0];
                  if (!debug_in.data[15])
                     kind_q <= ACCESS_READ;
                  else if (debug_in.data[14])
                     kind_q <= ACCESS_WRITE_BURST;
                  else
                     kind_q <= ACCESS_WRITE_SINGLE;
                  beats_q  <= debug_in.data[14] ? debug_in.data[BEATS_WIDTH-1:0]
                                                : BEATS_WIDTH'(1);
                  flit_cnt <= '0;
                  state    <= IN_ADDR;
               end
            end
            IN_ADDR: begin
               if (in_xfer) begin
                  addr_q   <= {addr_q[ADDR_WIDTH-17:0], debug_in.data}; // Upper half first
                  flit_cnt <= flit_cnt + 1'b1;
                  if (int'(flit_cnt) == ADDR_FLITS - 1) begin
                     last_seen <= debug_in.last;
                     state     <= IN_REQUEST;
                  end
               end
            end
            IN_REQUEST: begin
               if (req_ready) begin
                  word_cnt <= '0;
                  flit_cnt <= '0;
                  if (kind_q == ACCESS_READ)
                     state <= IN_READ_JOB;
                  else if (last_seen)
                     state <= IN_SKIP_HDR;   // Data follows in a new packet
                  else
                     state <= IN_WRITE_DATA;
               end
            end
            IN_WRITE_DATA: begin
               if (in_xfer) begin
                  word_q    <= {word_q[DATA_WIDTH-17:0], debug_in.data};
                  last_seen <= debug_in.last;
                  if (word_done) begin
                     word_cnt <= '0;
                     state    <= IN_WRITE_WAIT;
                  end else begin
                     word_cnt <= word_cnt + 1'b1;
                     // Word split across two packets
                     if (debug_in.last) begin
                        flit_cnt <= '0;
                        state    <= IN_SKIP_HDR;
                     end
                  end
               end
            end
            IN_WRITE_WAIT: begin
               if (write_ready) begin
                  beats_q  <= beats_q - 1'b1;
                  flit_cnt <= '0;
                  if (beats_q == BEATS_WIDTH'(1))
                     state <= IN_IDLE;
                  else if (last_seen)
                     state <= IN_SKIP_HDR;
                  else
                     state <= IN_WRITE_DATA;
               end
            end
            IN_SKIP_HDR: begin
               if (in_xfer) begin
                  flit_cnt <= flit_cnt + 1'b1;
                  if (int'(flit_cnt) == DII_HDR_FLITS - 1) state <= IN_WRITE_DATA;
               end
            end
            IN_READ_JOB: begin
               if (job_ready) state <= IN_IDLE;   // Egress answers on its own
            end
            default: state <= IN_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/mam_egress.sv
`timescale 1ns/1ps
`default_nettype none

module mam_egress
   import dii_pkg::*;
   import mam_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic [15:0]   id,
   input  logic          job_valid,
   input  mam_read_job_t read_job,
   output logic          job_ready,
   input  logic          read_valid,
   input  mam_word_t     read_data,
   output logic          read_ready,
   output dii_flit_t     debug_out,
   input  logic          debug_out_ready
);

   egress_state_e state;

   logic [15:0]                      dest_q;
   logic [BEATS_WIDTH-1:0]           beats_q;   // Words left including the current one
   logic [$clog2(MAX_PKT_LEN)-1:0]   pkt_cnt;   // Flits sent in this packet
   logic [$clog2(WORD_FLITS)-1:0]    word_cnt;

   logic word_done;
   logic pkt_full;
   logic final_flit;
   logic out_xfer;

   assign job_ready  = (state == EG_IDLE);
   assign word_done  = int'(word_cnt) == WORD_FLITS - 1;
   assign pkt_full   = int'(pkt_cnt) == MAX_PKT_LEN - 1;
   assign final_flit = word_done && (beats_q == BEATS_WIDTH'(1));
   assign out_xfer   = debug_out.valid && debug_out_ready;

   // Word is consumed with its lower flit
   assign read_ready = (state == EG_DATA) && out_xfer && word_done;

   always_comb begin
      debug_out = '0;
      case (state)
         EG_HDR: begin
            debug_out.valid = 1'b1;
            case (int'(pkt_cnt))
               0:       debug_out.data = dest_q;
               1:       debug_out.data = id;
               default: debug_out.data = DII_FLAGS_EVENT;
            endcase
         end
         EG_DATA: begin
            debug_out.valid = read_valid;
            debug_out.last  = pkt_full || final_flit;
            // Big-endian so the upper half goes first
            debug_out.data  = read_data[(WORD_FLITS - 1 - int'(word_cnt)) * 16 +: 16];
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= EG_IDLE;
         pkt_cnt  <= '0;
         word_cnt <= '0;
      end else begin
         case (state)
            EG_IDLE: begin
               if (job_valid) begin
                  dest_q   <= read_job.src;
                  beats_q  <= read_job.beats;
                  pkt_cnt  <= '0;
                  word_cnt <= '0;
                  state    <= EG_HDR;
               end
            end
            EG_HDR: begin
               if (out_xfer) begin
                  pkt_cnt <= pkt_cnt + 1'b1;
                  if (int'(pkt_cnt) == DII_HDR_FLITS - 1) state <= EG_DATA;
               end
            end
            EG_DATA: begin
               if (out_xfer) begin
                  if (word_done) begin
                     word_cnt <= '0;
                     beats_q  <= beats_q - 1'b1;
                  end else begin
                     word_cnt <= word_cnt + 1'b1;
                  end
                  if (final_flit) begin
                     state <= EG_IDLE;
                  end else if (pkt_full) begin
                     pkt_cnt <= '0;      // Reopen with a fresh header
                     state   <= EG_HDR;
                  end else begin
                     pkt_cnt <= pkt_cnt + 1'b1;
                  end
               end
            end
            default: state <= EG_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/mam_top.sv
`timescale 1ns/1ps
`default_nettype none

module mam_top
   import dii_pkg::*;
   import mam_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] id,

   input  dii_flit_t   debug_in,
   output logic        debug_in_ready,
   output dii_flit_t   debug_out,
   input  logic        debug_out_ready,

   output logic        req_valid,
   output mam_req_t    req,
   input  logic        req_ready,

   output logic        write_valid,
   output mam_word_t   write_data,
   output mam_strb_t   write_strb,
   input  logic        write_ready,

   input  logic        read_valid,
   input  mam_word_t   read_data,
   output logic        read_ready
);

   // Read hand-off from request parser to response builder
   logic          job_valid;
   logic          job_ready;
   mam_read_job_t read_job;

   mam_ingress ingress_i (
      .clk            (clk),
      .rst            (rst),
      .debug_in       (debug_in),
      .debug_in_ready (debug_in_ready),
      .req_valid      (req_valid),
      .req            (req),
      .req_ready      (req_ready),
      .write_valid    (write_valid),
      .write_data     (write_data),
      .write_strb     (write_strb),
      .write_ready    (write_ready),
      .job_valid      (job_valid),
      .read_job       (read_job),
      .job_ready      (job_ready)
   );

   mam_egress egress_i (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .job_valid       (job_valid),
      .read_job        (read_job),
      .job_ready       (job_ready),
      .read_valid      (read_valid),
      .read_data       (read_data),
      .read_ready      (read_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready)
   );

endmodule

`default_nettype wire

// File: bench/mam_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mam_tb
   import dii_pkg::*;
   import mam_pkg::*;
;
   typedef struct packed {
      mam_kind_e        kind;
      logic [31:0]      addr;
      logic [12:0]      beats;
      mam_strb_t        strb;
      mam_word_t        seed;   // Word n carries seed plus n
   } entry_t;

   localparam int NUM_ENTRIES = 7;

   entry_t tbl [NUM_ENTRIES] = '{
      '{ACCESS_WRITE_BURST,  32'h0000_2000, 13'd5, 4'hF, 32'h1000_0000},  // Three packets
      '{ACCESS_READ,         32'h0000_2000, 13'd5, 4'hF, 32'h0},
      '{ACCESS_WRITE_SINGLE, 32'h0000_2001, 13'd1, 4'h5, 32'hABCD_EF01},
      '{ACCESS_READ,         32'h0000_2001, 13'd1, 4'hF, 32'h0},
      '{ACCESS_WRITE_BURST,  32'h0000_3000, 13'd1, 4'hF, 32'h5555_AAAA},
      '{ACCESS_READ,         32'h0000_3000, 13'd1, 4'hF, 32'h0},
      '{ACCESS_READ,         32'h0000_2000, 13'd7, 4'hF, 32'h0}   // Splits words over packets
   };

   logic        clk;
   logic        rst;
   logic [15:0] id;
   dii_flit_t   debug_in;
   logic        debug_in_ready;
   dii_flit_t   debug_out;
   logic        debug_out_ready;
   logic        req_valid;
   mam_req_t    req;
   logic        req_ready;
   logic        write_valid;
   mam_word_t   write_data;
   mam_strb_t   write_strb;
   logic        write_ready;
   logic        read_valid;
   mam_word_t   read_data;
   logic        read_ready;

   integer      seed = 72166;
   logic        stall_en;
   mam_word_t   mem [logic [31:0]];      // Written by the DUT
   mam_word_t   ref_mem [logic [31:0]];  // Expected contents
   logic [31:0] rd_q [$];
   logic [31:0] wr_addr;
   dii_flit_t   exp_flits [$];
   mam_word_t   exp_words [$];
   mam_req_t    exp_reqs [$];

   mam_top dut_i (.*);

   always #50 clk = ~clk;

   task automatic fail_run(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic check_flit(input dii_flit_t got, input dii_flit_t exp);
      if (got !== exp) fail_run($sformatf("flit %h, expected %h", got, exp));
   endtask

   task automatic check_word(input mam_word_t got, input mam_word_t exp);
      if (got !== exp) fail_run($sformatf("write word %h, expected %h", got, exp));
   endtask

   task automatic check_req(input mam_req_t got, input mam_req_t exp);
      if (got !== exp) fail_run($sformatf("request %h, expected %h", got, exp));
   endtask

   // Unwritten locations read back a pattern of their address
   function automatic mam_word_t fill_word(input logic [31:0] a);
      return a ^ 32'h5A5A_A5A5;
   endfunction

   function automatic mam_word_t merge(input mam_word_t old, input mam_word_t nw,
                                       input mam_strb_t s);
      mam_word_t r;
      r = old;
      for (int b = 0; b < DATA_BYTES; b++)
         if (s[b]) r[b*8 +: 8] = nw[b*8 +: 8];
      return r;
   endfunction

   function automatic dii_flit_t make_flit(input logic [15:0] data, input logic last);
      dii_flit_t f;
      f.valid = 1'b1;
      f.last  = last;
      f.data  = data;
      return f;
   endfunction

   function automatic logic roll();
      return stall_en ? (($random(seed) & 3) != 0) : 1'b1;
   endfunction

   // Memory model and stall source
   always @(posedge clk) begin
      if (rst) begin
         req_ready       <= 1'b0;
         write_ready     <= 1'b0;
         read_valid      <= 1'b0;
         debug_out_ready <= 1'b0;
      end else begin
         if (req_valid && req_ready) begin
            if (exp_reqs.size() == 0) fail_run("unexpected memory request");
            check_req(req, exp_reqs.pop_front());
            if (req.we) wr_addr = req.addr;
            else for (int n = 0; n < int'(req.beats); n++) rd_q.push_back(req.addr + n);
         end
         if (write_valid && write_ready) begin
            if (exp_words.size() == 0) fail_run("unexpected write word");
            check_word(write_data, exp_words.pop_front());
            mem[wr_addr] = merge(mem.exists(wr_addr) ? mem[wr_addr] : fill_word(wr_addr),
                                 write_data, write_strb);
            wr_addr = wr_addr + 1;
         end
         if (read_valid && read_ready) void'(rd_q.pop_front());
         req_ready       <= roll();
         write_ready     <= roll();
         debug_out_ready <= roll();
         if (rd_q.size() > 0) begin
            read_valid <= roll();
            read_data  <= mem.exists(rd_q[0]) ? mem[rd_q[0]] : fill_word(rd_q[0]);
         end else begin
            read_valid <= 1'b0;
         end
      end
   end

   // Response collector
   always @(posedge clk) begin
      if (!rst && debug_out.valid && debug_out_ready) begin
         if (exp_flits.size() == 0) fail_run("unexpected response flit");
         check_flit(debug_out, exp_flits.pop_front());
      end
   end

   task automatic send_flit(input logic [15:0] data, input logic last);
      debug_in <= make_flit(data, last);
      do @(posedge clk); while (!debug_in_ready);
   endtask

   task automatic run_entry(input entry_t e, input logic [15:0] src);
      logic [15:0] pl [$];
      logic [15:0] df [$];
      mam_req_t    r;
      mam_word_t   w;
      logic [31:0] a;
      int          pos;
      r.we    = (e.kind != ACCESS_READ);
      r.burst = (e.kind == ACCESS_WRITE_BURST) || (e.kind == ACCESS_READ && e.beats > 1);
      r.addr  = e.addr;
      r.beats = e.beats;
      exp_reqs.push_back(r);
      pl.push_back({r.we, r.burst, 1'b0, r.burst ? e.beats : 13'(e.strb)});
      pl.push_back(e.addr[31:16]);
      pl.push_back(e.addr[15:0]);
      for (int n = 0; n < int'(e.beats); n++) begin
         a = e.addr + n;
         w = ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
         if (r.we) begin
            exp_words.push_back(e.seed + n);
            ref_mem[a] = merge(w, e.seed + n,
                               (e.kind == ACCESS_WRITE_SINGLE) ? e.strb : 4'hF);
            pl.push_back(16'((e.seed + n) >> 16));
            pl.push_back(16'(e.seed + n));
         end else begin
            df.push_back(w[31:16]);
            df.push_back(w[15:0]);
         end
      end
      // Expected response packets with headers reopened at MAX_PKT_LEN
      pos = 0;
      foreach (df[k]) begin
         if (pos == 0) begin
            exp_flits.push_back(make_flit(src, 1'b0));
            exp_flits.push_back(make_flit(id, 1'b0));
            exp_flits.push_back(make_flit(DII_FLAGS_EVENT, 1'b0));
            pos = DII_HDR_FLITS;
         end
         exp_flits.push_back(make_flit(df[k],
                                       (pos == MAX_PKT_LEN - 1) || (k == df.size() - 1)));
         pos = (pos == MAX_PKT_LEN - 1) ? 0 : pos + 1;
      end
      // Request packets with write data continued behind fresh headers
      pos = 0;
      foreach (pl[k]) begin
         if (pos == 0) begin
            send_flit(id, 1'b0);
            send_flit(src, 1'b0);
            send_flit(16'h0000, 1'b0);
            pos = DII_HDR_FLITS;
         end
         send_flit(pl[k], (pos == MAX_PKT_LEN - 1) || (k == pl.size() - 1));
         pos = (pos == MAX_PKT_LEN - 1) ? 0 : pos + 1;
      end
      debug_in <= '0;
      while (exp_flits.size() != 0 || exp_words.size() != 0 || exp_reqs.size() != 0)
         @(posedge clk);
   endtask

   initial begin
      int total;
      total = 0;
      foreach (tbl[i]) total += int'(tbl[i].beats);
      repeat (2 * total * 40 + 200) @(posedge clk);
      $display("Watchdog expired, the run timed out");
      $display("Result: FAILED");
      $fatal(1);
   end

   initial begin
      clk             = 1'b0;
      rst             = 1'b1;
      id              = 16'h0007;
      debug_in        = '0;
      debug_out_ready = 1'b0;
      req_ready       = 1'b0;
      write_ready     = 1'b0;
      read_valid      = 1'b0;
      read_data       = '0;
      stall_en        = 1'b0;
      wr_addr         = '0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      repeat (5) begin
         @(posedge clk);
         if (req_valid || write_valid || read_ready || debug_out.valid || !debug_in_ready)
            fail_run("DUT active while debug_in is idle");
      end
      // Second pass repeats the table under random stalls
      for (int pass = 0; pass < 2; pass++) begin
         stall_en <= pass[0];
         for (int i = 0; i < NUM_ENTRIES; i++) run_entry(tbl[i], 16'h0040 + 16'(i));
      end
      repeat (5) @(posedge clk);
      if (rd_q.size() == 0) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         $display("Read words left unconsumed at the end of the run");
         $display("Result: FAILED");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// File: build.f
hw/dii_pkg.sv
hw/mam_pkg.sv
hw/mam_ingress.sv
hw/mam_egress.sv
hw/mam_top.sv
bench/mam_tb.sv

// File: Makefile
# Verilator build and run of the debug memory access testbench

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f build.f --top-module mam_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vmam_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

lint:
	verilator --lint-only --timing -f build.f --top-module mam_tb

clean:
	rm -rf obj_dir
